// ==== logic/baud_tick_gen.sv ====
`timescale 1ns/1ps

module baud_tick_gen #(
    parameter int CLKS_PER_TICK = 27
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    // counter must hold CLKS_PER_TICK-1, and at least one bit.
    localparam int CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLKS_PER_TICK - 1);

    logic [CNT_W-1:0] cnt;

    // count down, tick on the cycle the counter reloads.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= RELOAD;
            tick <= 1'b0;
        end else begin
            if (cnt == '0) begin
                cnt  <= RELOAD;
                tick <= 1'b1;
            end else begin
                cnt  <= cnt - 1'b1;
                tick <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/uart_fifo.sv ====
`timescale 1ns/1ps

module uart_fifo #(
    parameter int  FIFO_DEPTH = 4,
    parameter type payload_t  = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     empty,
    output logic     full,
    output logic     overflow
);

    // depth is a power of two, so the pointers wrap by themselves.
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    payload_t           mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               do_wr;
    logic               do_rd;

    assign empty    = (count == '0);
    assign full     = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign do_wr    = wr_en && !full;
    assign do_rd    = rd_en && !empty;
    assign overflow = wr_en && full;    // write dropped.
    assign rd_data  = mem[rd_ptr];      // head shown without a read.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage.
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

// ==== logic/uart_pkg.sv ====
package uart_pkg;

    // ##############################
    // payload types
    // ##############################

    typedef logic [7:0] byte_t;

    // one received frame as it leaves the receiver.
    typedef struct packed {
        logic  frame_err; // stop bit was sampled low.
        byte_t data;
    } rx_frame_t;

    // ##############################
    // oversampling
    // ##############################

    localparam int OVERSAMPLE = 16;             // ticks per bit.
    localparam int HALF_BIT   = OVERSAMPLE / 2; // ticks to middle of start bit.
    localparam int DATA_BITS  = $bits(byte_t);

    // tick count within one bit, 0 .. OVERSAMPLE-1.
    typedef logic [$clog2(OVERSAMPLE)-1:0] tick_cnt_t;

    // bit index within the data field, 0 .. DATA_BITS-1.
    typedef logic [$clog2(DATA_BITS)-1:0] bit_cnt_t;

endpackage

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx,
    input  logic                 tick,
    output uart_pkg::rx_frame_t  rx_frame,
    output logic                 rx_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    localparam uart_pkg::tick_cnt_t MID_START = uart_pkg::tick_cnt_t'(uart_pkg::HALF_BIT - 1);
    localparam uart_pkg::tick_cnt_t LAST_TICK = uart_pkg::tick_cnt_t'(uart_pkg::OVERSAMPLE - 1);
    localparam uart_pkg::bit_cnt_t  LAST_BIT  = uart_pkg::bit_cnt_t'(uart_pkg::DATA_BITS - 1);

    state_t               state;
    uart_pkg::tick_cnt_t  tick_cnt;
    uart_pkg::bit_cnt_t   bit_cnt;
    uart_pkg::byte_t      shift;
    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_last;

    // ##############################
    // input synchronizer
    // ##############################

    // the line idles high, so the flops come out of reset high.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    // ##############################
    // receive FSM
    // ##############################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                st_idle: begin
                    // a falling edge only, so a line still low after a bad
                    // stop bit does not open another frame.
                    if (rx_last && !rx_sync) begin
                        state    <= st_start;
                        tick_cnt <= '0;
                    end
                end
                st_start: begin
                    if (tick) begin
                        if (tick_cnt == MID_START) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= rx_sync ? st_idle : st_data; // false start.
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                st_data: begin
                    if (tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            if (bit_cnt == LAST_BIT) begin
                                state <= st_stop;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                st_stop: begin
                    if (tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            rx_valid <= 1'b1; // delivered even on a framing error.
                            state    <= st_idle;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // data path, LSB arrives first so bits enter at the top.
    always_ff @(posedge clk) begin
        if (state == st_data && tick && tick_cnt == LAST_TICK) begin
            shift <= {rx_sync, shift[7:1]};
        end
        if (state == st_stop && tick && tick_cnt == LAST_TICK) begin
            rx_frame.data      <= shift;
            rx_frame.frame_err <= !rx_sync;
        end
    end

endmodule

// ==== logic/uart_top.sv ====
`timescale 1ns/1ps

module uart_top #(
    parameter int CLKS_PER_TICK = 27,
    parameter int FIFO_DEPTH    = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx,
    output logic                 tx,
    input  uart_pkg::byte_t      tx_data,
    input  logic                 tx_wr,
    output logic                 tx_full,
    output logic                 tx_busy,
    output uart_pkg::rx_frame_t  rx_frame,
    input  logic                 rx_rd,
    output logic                 rx_empty,
    output logic                 rx_overrun
);

    logic                 tick;
    uart_pkg::rx_frame_t  rx_word;
    logic                 rx_valid;
    uart_pkg::byte_t      tx_head;
    logic                 tx_empty;
    logic                 tx_rd;

    // ##############################
    // bit rate
    // ##############################

    baud_tick_gen #(
        .CLKS_PER_TICK (CLKS_PER_TICK)
    ) baud0 (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    // ##############################
    // receive path
    // ##############################

    uart_rx rx0 (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .tick     (tick),
        .rx_frame (rx_word),
        .rx_valid (rx_valid)
    );

    uart_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (uart_pkg::rx_frame_t)
    ) rx_fifo0 (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (rx_valid),
        .wr_data  (rx_word),
        .rd_en    (rx_rd),
        .rd_data  (rx_frame),
        .empty    (rx_empty),
        .full     (),
        .overflow (rx_overrun)      // frame lost.
    );

    // ##############################
    // transmit path
    // ##############################

    uart_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (uart_pkg::byte_t)
    ) tx_fifo0 (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (tx_wr),
        .wr_data  (tx_data),
        .rd_en    (tx_rd),
        .rd_data  (tx_head),
        .empty    (tx_empty),
        .full     (tx_full),
        .overflow ()                // user watches tx_full instead.
    );

    uart_tx tx0 (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .tx_data  (tx_head),
        .tx_empty (tx_empty),
        .tx_rd    (tx_rd),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic             clk,
    input  logic             rst,
    input  logic             tick,
    input  uart_pkg::byte_t  tx_data,
    input  logic             tx_empty,
    output logic             tx_rd,
    output logic             tx,
    output logic             tx_busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    localparam uart_pkg::tick_cnt_t LAST_TICK = uart_pkg::tick_cnt_t'(uart_pkg::OVERSAMPLE - 1);
    localparam uart_pkg::bit_cnt_t  LAST_BIT  = uart_pkg::bit_cnt_t'(uart_pkg::DATA_BITS - 1);

    state_t               state;
    uart_pkg::tick_cnt_t  tick_cnt;
    uart_pkg::bit_cnt_t   bit_cnt;
    uart_pkg::byte_t      shift;

    // pop the FIFO head as soon as we are idle and it holds a byte.
    assign tx_rd   = (state == st_idle) && !tx_empty;
    assign tx_busy = (state != st_idle) || tx_rd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    tx <= 1'b1;
                    if (tx_rd) begin
                        state    <= st_start;
                        tick_cnt <= '0;
                        tx       <= 1'b0; // start bit.
                    end
                end
                st_start: begin
                    if (tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            tx       <= shift[0];
                            state    <= st_data;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                st_data: begin
                    if (tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            if (bit_cnt == LAST_BIT) begin
                                tx    <= 1'b1; // stop bit.
                                state <= st_stop;
                            end else begin
                                tx      <= shift[1];
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                st_stop: begin
                    if (tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            state <= st_idle;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // shift register, loaded on the pop and moved right per data bit.
    always_ff @(posedge clk) begin
        if (tx_rd) begin
            shift <= tx_data;
        end else if (state == st_data && tick && tick_cnt == LAST_TICK) begin
            shift <= {1'b1, shift[7:1]};
        end
    end

endmodule

// ==== sources.f ====
logic/uart_pkg.sv
logic/baud_tick_gen.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_fifo.sv
logic/uart_top.sv
testbench/uart_assert.sv
testbench/uart_tb.sv

// ==== testbench/uart_assert.sv ====
`timescale 1ns/1ps

module uart_assert (
    input logic clk,
    input logic rst,
    input logic tx,
    input logic tx_busy,
    input logic rx_valid,
    input logic rx_overrun,
    input logic rx_full
);

    int fail_cnt = 0;

    // line rests high between frames.
    tx_idle_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> tx)
        else begin
            fail_cnt++;
            $error("tx low while the transmitter is idle");
        end

    rx_valid_single: assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid)
        else begin
            fail_cnt++;
            $error("rx_valid high for two cycles");
        end

    overrun_when_full: assert property (@(posedge clk) disable iff (rst) rx_overrun |-> rx_full)
        else begin
            fail_cnt++;
            $error("rx_overrun while the receive FIFO has room");
        end

endmodule

bind uart_top uart_assert assert0 (
    .clk        (clk),
    .rst        (rst),
    .tx         (tx),
    .tx_busy    (tx_busy),
    .rx_valid   (rx_valid),
    .rx_overrun (rx_overrun),
    .rx_full    (rx_fifo0.full)
);

// ==== testbench/uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb;

    localparam int CLKS_PER_TICK = 4;
    localparam int FIFO_DEPTH    = 4;
    localparam int BIT_CLKS      = uart_pkg::OVERSAMPLE * CLKS_PER_TICK;
    localparam int TABLE_LEN     = 12;
    localparam logic [1:0] K_RX    = 2'd0;
    localparam logic [1:0] K_FALSE = 2'd1;
    localparam logic [1:0] K_TX    = 2'd2;

    typedef struct packed {
        logic [1:0]      kind;
        uart_pkg::byte_t data;
        logic            stop; // stop bit level driven on rx.
        logic            ferr; // expected frame_err.
    } stim_t;

    logic                 clk;
    logic                 rst;
    logic                 rx;
    logic                 tx;
    uart_pkg::byte_t      tx_data;
    logic                 tx_wr;
    logic                 tx_full;
    logic                 tx_busy;
    uart_pkg::rx_frame_t  rx_frame;
    logic                 rx_rd;
    logic                 rx_empty;
    logic                 rx_overrun;

    stim_t                stim_tab [TABLE_LEN];
    uart_pkg::byte_t      tx_got [$];
    logic                 tx_stop [$];
    logic [31:0]          rng = 32'd63642;
    int                   n_checks = 0;
    int                   n_mismatch = 0;
    int                   n_other = 0;
    int                   overrun_cnt = 0;

    uart_top #(
        .CLKS_PER_TICK (CLKS_PER_TICK),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) dut0 (
        .clk (clk), .rst (rst), .rx (rx), .tx (tx),
        .tx_data (tx_data), .tx_wr (tx_wr), .tx_full (tx_full), .tx_busy (tx_busy),
        .rx_frame (rx_frame), .rx_rd (rx_rd), .rx_empty (rx_empty),
        .rx_overrun (rx_overrun)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // roughly 12 bit periods per table entry, plus the burst and overrun runs.
    initial begin
        #((TABLE_LEN + 4 * (FIFO_DEPTH + 1)) * 12 * BIT_CLKS * 20);
        $display("timeout: simulation did not complete in the expected time");
        $display("CHECKS FAILED");
        $finish;
    end

    always @(negedge clk) begin
        if (rx_overrun === 1'b1) begin
            overrun_cnt++;
        end
    end

    // ##############################
    // helpers
    // ##############################

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic uart_pkg::byte_t rand_byte();
        rng = xorshift32(rng);
        return rng[7:0];
    endfunction

    task automatic step(input int n = 1);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic other_error(input string msg);
        n_other++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic check_frame(input string name, input uart_pkg::rx_frame_t got,
                               input uart_pkg::rx_frame_t exp);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t: %s got data %h err %b, expected data %h err %b",
                     $time, name, got.data, got.frame_err, exp.data, exp.frame_err);
        end
    endtask

    task automatic check_byte(input string name, input uart_pkg::byte_t got,
                              input uart_pkg::byte_t exp);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // start bit, eight data bits lsb first, then the given stop level.
    task automatic send_rx(input uart_pkg::byte_t b, input logic stop);
        logic [9:0] bits;
        bits = {stop, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = bits[i];
            step(BIT_CLKS);
        end
        rx = 1'b1;
        step(BIT_CLKS);
    endtask

    task automatic decode_tx(output uart_pkg::byte_t b, output logic stop);
        @(negedge tx);
        repeat (BIT_CLKS / 2) @(negedge clk); // middle of the start bit.
        check_bit("tx start bit", tx, 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            b[i] = tx;
        end
        repeat (BIT_CLKS) @(negedge clk);
        stop = tx;
    endtask

    task automatic wait_rx_ready();
        int n;
        n = 0;
        while (rx_empty && n < 2 * BIT_CLKS) begin
            step();
            n++;
        end
        if (rx_empty) begin
            other_error("no frame reached the receive FIFO");
        end
    endtask

    task automatic wait_tx_count(input int cnt);
        int n;
        n = 0;
        while (tx_got.size() < cnt && n < cnt * 12 * BIT_CLKS) begin
            step();
            n++;
        end
        if (tx_got.size() < cnt) begin
            other_error("expected byte never appeared on tx");
        end
    endtask

    task automatic wait_tx_idle();
        int n;
        n = 0;
        while (tx_busy && n < 24 * BIT_CLKS) begin
            step();
            n++;
        end
        if (tx_busy) begin
            other_error("transmitter never went idle");
        end
    endtask

    task automatic read_rx();
        rx_rd = 1'b1;
        step();
        rx_rd = 1'b0;
    endtask

    task automatic write_tx(input uart_pkg::byte_t b);
        tx_data = b;
        tx_wr   = 1'b1;
        step();
        tx_wr   = 1'b0;
    endtask

    task automatic build_table();
        stim_tab[0]  = '{K_RX, 8'h55, 1'b1, 1'b0};
        stim_tab[1]  = '{K_RX, 8'hA3, 1'b1, 1'b0};
        stim_tab[2]  = '{K_RX, rand_byte(), 1'b1, 1'b0};
        stim_tab[3]  = '{K_RX, 8'h3C, 1'b0, 1'b1}; // framing error.
        stim_tab[4]  = '{K_FALSE, 8'h00, 1'b1, 1'b0};
        stim_tab[5]  = '{K_RX, rand_byte(), 1'b1, 1'b0};
        stim_tab[6]  = '{K_TX, 8'h55, 1'b1, 1'b0};
        stim_tab[7]  = '{K_TX, 8'h81, 1'b1, 1'b0};
        stim_tab[8]  = '{K_TX, rand_byte(), 1'b1, 1'b0};
        stim_tab[9]  = '{K_RX, 8'h00, 1'b0, 1'b1};
        stim_tab[10] = '{K_TX, rand_byte(), 1'b1, 1'b0};
        stim_tab[11] = '{K_RX, 8'hFF, 1'b1, 1'b0};
    endtask

    // decoded tx bytes collect here in order.
    initial begin
        uart_pkg::byte_t b;
        logic            s;
        @(negedge rst);
        forever begin
            decode_tx(b, s);
            tx_got.push_back(b);
            tx_stop.push_back(s);
        end
    end

    // ##############################
    // test sequence
    // ##############################

    initial begin
        stim_t               e;
        uart_pkg::rx_frame_t exp;
        uart_pkg::byte_t     sent [$];
        rst     = 1'b1;
        rx      = 1'b1;
        tx_data = '0;
        tx_wr   = 1'b0;
        rx_rd   = 1'b0;
        build_table();
        step(2);
        rst = 1'b0;
        step();
        check_bit("tx", tx, 1'b1);
        check_bit("tx_busy", tx_busy, 1'b0);
        check_bit("rx_empty", rx_empty, 1'b1);
        check_bit("tx_full", tx_full, 1'b0);
        check_bit("rx_overrun", rx_overrun, 1'b0);

        foreach (stim_tab[i]) begin
            e = stim_tab[i];
            case (e.kind)
                K_RX: begin
                    send_rx(e.data, e.stop);
                    wait_rx_ready();
                    exp.data      = e.data;
                    exp.frame_err = e.ferr;
                    check_frame("rx_frame", rx_frame, exp);
                    read_rx();
                    check_bit("rx_empty after read", rx_empty, 1'b1);
                end
                K_FALSE: begin
                    rx = 1'b0; // quarter bit glitch.
                    step(BIT_CLKS / 4);
                    rx = 1'b1;
                    step(12 * BIT_CLKS); // a whole frame would have landed by now.
                    check_bit("rx_empty after false start", rx_empty, 1'b1);
                end
                default: begin
                    write_tx(e.data);
                    wait_tx_count(1);
                    check_byte("tx byte", tx_got.pop_front(), e.data);
                    check_bit("tx stop bit", tx_stop.pop_front(), 1'b1);
                end
            endcase
        end

        // one byte in flight, then FIFO_DEPTH+1 writes; the last is dropped.
        wait_tx_idle();
        sent.push_back(rand_byte());
        write_tx(sent[0]);
        step(2);
        check_bit("tx_busy", tx_busy, 1'b1);
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            sent.push_back(rand_byte());
            check_bit("tx_full", tx_full, i == FIFO_DEPTH);
            write_tx(sent[i + 1]);
        end
        wait_tx_count(FIFO_DEPTH + 1);
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            check_byte("tx burst byte", tx_got.pop_front(), sent[i]);
            check_bit("tx burst stop bit", tx_stop.pop_front(), 1'b1);
        end
        step(12 * BIT_CLKS);
        check_bit("tx silent after burst", tx_got.size() == 0, 1'b1);

        // overrun, nothing read until all frames are in.
        sent.delete();
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            sent.push_back(rand_byte());
            send_rx(sent[i], 1'b1);
        end
        check_bit("single rx_overrun pulse", overrun_cnt == 1, 1'b1);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            exp.data      = sent[i];
            exp.frame_err = 1'b0;
            check_frame("rx_frame after overrun", rx_frame, exp);
            read_rx();
        end
        check_bit("rx_empty after overrun", rx_empty, 1'b1);

        $display("summary: %0d checks, %0d mismatches, %0d other errors, %0d assertion failures",
                 n_checks, n_mismatch, n_other, dut0.assert0.fail_cnt);
        if (n_mismatch + n_other + dut0.assert0.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
